// File: source/soc_pkg.sv
package soc_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// On-chip word memory
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = 8;

	// Address map
	localparam logic [ADDR_W-1:0] MEM_BASE       = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] MEM_LAST       = 32'h0000_03FF;
	localparam logic [ADDR_W-1:0] GPIO_ADDR      = 32'h0000_1000;
	localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 32'h0000_2000;
	localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 32'h0000_2004;

	// Clocks per serial bit, both directions
	localparam int CLKS_PER_BIT = 16;

	localparam int SW_W  = 4;
	localparam int LED_W = 8;

	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
	} bus_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              err;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		REG_MEM,
		REG_GPIO,
		REG_UART,
		REG_NONE
	} region_e;

	// Shared by receiver and transmitter
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} uart_state_e;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       rx_i,
	output logic       byte_stb_o,
	output logic [7:0] byte_o
);
	import soc_pkg::*;

	logic [1:0] sync_q;
	logic rx_s;
	uart_state_e state_q;
	logic [$clog2(CLKS_PER_BIT+1)-1:0] cnt_q;
	logic [2:0] bit_q;
	logic [7:0] shift_q;
	logic stb_q;
	logic [7:0] byte_q;

	// Two-flop synchronizer, idle high
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) sync_q <= 2'b11;
		else sync_q <= {sync_q[0], rx_i};
	end
	assign rx_s = sync_q[1];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			stb_q   <= 1'b0;
		end else begin
			stb_q <= 1'b0;
			cnt_q <= cnt_q + 1'b1;
			case (state_q)
				ST_IDLE: begin
					cnt_q <= '0;
					if (!rx_s) state_q <= ST_START;
				end
				ST_START: begin
					// Recheck at mid start bit to reject glitches
					if (cnt_q == CLKS_PER_BIT/2 - 1) begin
						cnt_q   <= '0;
						bit_q   <= '0;
						state_q <= rx_s ? ST_IDLE : ST_DATA;
					end
				end
				ST_DATA: begin
					if (cnt_q == CLKS_PER_BIT - 1) begin
						cnt_q   <= '0;
						shift_q <= {rx_s, shift_q[7:1]};
						bit_q   <= bit_q + 1'b1;
						if (bit_q == 3'd7) state_q <= ST_STOP;
					end
				end
				ST_STOP: begin
					if (cnt_q == CLKS_PER_BIT - 1) begin
						stb_q  <= rx_s;
						byte_q <= shift_q;
					end else if (cnt_q == CLKS_PER_BIT) begin
						state_q <= ST_IDLE;
					end
				end
			endcase
		end
	end

	assign byte_stb_o = stb_q;
	assign byte_o     = byte_q;

	// Strobe only leaves the stop bit
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		byte_stb_o |-> (state_q == ST_STOP && $past(state_q) == ST_STOP));

endmodule

// File: source/prog_loader.sv
`timescale 1ns/10ps

module prog_loader (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              reprog_i,
	input  logic              byte_stb_i,
	input  logic [7:0]        byte_i,
	output logic              ld_stb_o,
	output soc_pkg::bus_req_t ld_req_o
);
	import soc_pkg::*;

	logic [1:0] cnt_q;
	logic [MEM_IDX_W-1:0] idx_q;
	logic [DATA_W-1:0] word_q;
	logic stb_q;
	bus_req_t req_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
			idx_q <= '0;
			stb_q <= 1'b0;
		end else begin
			stb_q <= 1'b0;
			if (!reprog_i) begin
				cnt_q <= '0;
				idx_q <= '0;
			end else if (byte_stb_i) begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == 2'd3) begin
					stb_q <= 1'b1;
					idx_q <= idx_q + 1'b1;
				end
			end
		end
	end

	// Little-endian assembly, last byte goes straight into the request
	always_ff @(posedge clk_i) begin
		if (reprog_i && byte_stb_i) begin
			word_q[8*cnt_q +: 8] <= byte_i;
			if (cnt_q == 2'd3) begin
				req_q.write <= 1'b1;
				req_q.addr  <= {{(ADDR_W-MEM_IDX_W-2){1'b0}}, idx_q, 2'b00};
				req_q.wdata <= {byte_i, word_q[23:0]};
				req_q.strb  <= '1;
			end
		end
	end

	assign ld_stb_o = stb_q;
	assign ld_req_o = req_q;

endmodule

// File: source/bus_fabric.sv
`timescale 1ns/10ps

module bus_fabric (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      reprog_i,
	input  logic                      host_stb_i,
	input  soc_pkg::bus_req_t         host_req_i,
	input  logic                      ld_stb_i,
	input  soc_pkg::bus_req_t         ld_req_i,
	output logic                      mem_stb_o,
	output soc_pkg::bus_req_t         mem_req_o,
	input  logic [soc_pkg::DATA_W-1:0] mem_rdata_i,
	output logic                      reg_stb_o,
	output soc_pkg::bus_req_t         reg_req_o,
	input  logic [soc_pkg::DATA_W-1:0] reg_rdata_i,
	output logic                      rsp_stb_o,
	output soc_pkg::bus_rsp_t         rsp_o
);
	import soc_pkg::*;

	logic sel_stb;
	bus_req_t sel_req;
	region_e region;
	region_e region_q;
	logic rsp_stb_q;

	// Loader owns the bus while reprogramming
	assign sel_stb = reprog_i ? ld_stb_i : host_stb_i;
	assign sel_req = reprog_i ? ld_req_i : host_req_i;

	always_comb begin
		if (sel_req.addr >= MEM_BASE && sel_req.addr <= MEM_LAST)
			region = REG_MEM;
		else if (sel_req.addr == GPIO_ADDR)
			region = REG_GPIO;
		else if (sel_req.addr == UART_DATA_ADDR || sel_req.addr == UART_STAT_ADDR)
			region = REG_UART;
		else
			region = REG_NONE;
	end

	assign mem_stb_o = sel_stb && (region == REG_MEM);
	assign reg_stb_o = sel_stb && (region == REG_GPIO || region == REG_UART);
	assign mem_req_o = sel_req;
	assign reg_req_o = sel_req;

	// Only host requests get a response
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rsp_stb_q <= 1'b0;
			region_q  <= REG_NONE;
		end else begin
			rsp_stb_q <= host_stb_i && !reprog_i;
			if (sel_stb) region_q <= region;
		end
	end

	always_comb begin
		rsp_o = '{rdata: '0, err: 1'b0};
		case (region_q)
			REG_MEM:            rsp_o.rdata = mem_rdata_i;
			REG_GPIO, REG_UART: rsp_o.rdata = reg_rdata_i;
			default:            rsp_o.err   = 1'b1;
		endcase
	end

	assign rsp_stb_o = rsp_stb_q;

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(mem_stb_o && reg_stb_o));

endmodule

// File: source/word_ram.sv
`timescale 1ns/10ps

module word_ram (
	input  logic                       clk_i,
	input  logic                       mem_stb_i,
	input  soc_pkg::bus_req_t          mem_req_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem_q [MEM_WORDS];
	logic [MEM_IDX_W-1:0] idx;
	logic [DATA_W-1:0] rdata_q;

	// Word index, byte offset dropped
	assign idx = mem_req_i.addr[MEM_IDX_W+1:2];

	always_ff @(posedge clk_i) begin
		if (mem_stb_i) begin
			if (mem_req_i.write) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (mem_req_i.strb[b])
						mem_q[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
				end
			end
			rdata_q <= mem_q[idx];
		end
	end

	assign rdata_o = rdata_q;

endmodule

// File: source/periph_regs.sv
`timescale 1ns/10ps

module periph_regs (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       reprog_i,
	input  logic                       reg_stb_i,
	input  soc_pkg::bus_req_t          reg_req_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o,
	input  logic [soc_pkg::SW_W-1:0]   sw_i,
	output logic [soc_pkg::LED_W-1:0]  led_o,
	input  logic                       tx_busy_i,
	output logic                       tx_stb_o,
	output logic [7:0]                 tx_byte_o
);
	import soc_pkg::*;

	logic wr;
	logic busy;
	logic [LED_W-1:0] led_q;
	logic tx_stb_q;
	logic [7:0] tx_byte_q;
	logic [DATA_W-1:0] rdata_q;

	assign wr = reg_stb_i && reg_req_i.write && reg_req_i.strb[0];

	// Busy covers the cycle before the transmitter picks up the byte
	assign busy = tx_busy_i || tx_stb_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			led_q    <= '0;
			tx_stb_q <= 1'b0;
		end else begin
			tx_stb_q <= wr && reg_req_i.addr == UART_DATA_ADDR && !busy;
			if (reprog_i)
				led_q <= '0;
			else if (wr && reg_req_i.addr == GPIO_ADDR)
				led_q <= reg_req_i.wdata[LED_W-1:0];
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr && reg_req_i.addr == UART_DATA_ADDR && !busy)
			tx_byte_q <= reg_req_i.wdata[7:0];
	end

	always_ff @(posedge clk_i) begin
		if (reg_stb_i) begin
			case (reg_req_i.addr)
				GPIO_ADDR:      rdata_q <= {{(DATA_W-SW_W){1'b0}}, sw_i};
				UART_STAT_ADDR: rdata_q <= {{(DATA_W-1){1'b0}}, busy};
				default:        rdata_q <= '0;
			endcase
		end
	end

	assign rdata_o   = rdata_q;
	assign led_o     = led_q;
	assign tx_stb_o  = tx_stb_q;
	assign tx_byte_o = tx_byte_q;

endmodule

// File: source/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       tx_stb_i,
	input  logic [7:0] tx_byte_i,
	output logic       busy_o,
	output logic       tx_o
);
	import soc_pkg::*;

	uart_state_e state_q;
	logic [$clog2(CLKS_PER_BIT)-1:0] cnt_q;
	logic [2:0] bit_q;
	logic [7:0] shift_q;
	logic tx_q;
	logic bit_done;

	assign bit_done = (cnt_q == CLKS_PER_BIT - 1);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			tx_q    <= 1'b1;
		end else begin
			cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
			case (state_q)
				ST_IDLE: begin
					cnt_q <= '0;
					if (tx_stb_i) begin
						state_q <= ST_START;
						shift_q <= tx_byte_i;
						tx_q    <= 1'b0;
					end
				end
				ST_START: begin
					if (bit_done) begin
						state_q <= ST_DATA;
						bit_q   <= '0;
						tx_q    <= shift_q[0];
						shift_q <= {1'b0, shift_q[7:1]};
					end
				end
				ST_DATA: begin
					if (bit_done) begin
						bit_q   <= bit_q + 1'b1;
						tx_q    <= shift_q[0];
						shift_q <= {1'b0, shift_q[7:1]};
						if (bit_q == 3'd7) begin
							state_q <= ST_STOP;
							tx_q    <= 1'b1;
						end
					end
				end
				ST_STOP: begin
					if (bit_done) state_q <= ST_IDLE;
				end
			endcase
		end
	end

	assign busy_o = (state_q != ST_IDLE);
	assign tx_o   = tx_q;

	// Register block must hold off new bytes for the whole frame
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tx_stb_i |-> !busy_o);

endmodule

// File: source/soc_top.sv
`timescale 1ns/10ps

module soc_top (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      req_stb_i,
	input  soc_pkg::bus_req_t         req_i,
	output logic                      rsp_stb_o,
	output soc_pkg::bus_rsp_t         rsp_o,
	input  logic                      reprog_i,
	input  logic [soc_pkg::SW_W-1:0]  sw_i,
	output logic [soc_pkg::LED_W-1:0] led_o,
	input  logic                      uart_rx_i,
	output logic                      uart_tx_o
);
	import soc_pkg::*;

	logic rx_stb;
	logic [7:0] rx_byte;
	logic ld_stb;
	bus_req_t ld_req;
	logic mem_stb;
	bus_req_t mem_req;
	logic [DATA_W-1:0] mem_rdata;
	logic reg_stb;
	bus_req_t reg_req;
	logic [DATA_W-1:0] reg_rdata;
	logic tx_stb;
	logic [7:0] tx_byte;
	logic tx_busy;

	// Input side
	uart_rx uart_rx_i0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .rx_i(uart_rx_i),
		.byte_stb_o(rx_stb), .byte_o(rx_byte)
	);

	prog_loader prog_loader_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .reprog_i(reprog_i),
		.byte_stb_i(rx_stb), .byte_i(rx_byte),
		.ld_stb_o(ld_stb), .ld_req_o(ld_req)
	);

	// Fabric and memory
	bus_fabric bus_fabric_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .reprog_i(reprog_i),
		.host_stb_i(req_stb_i), .host_req_i(req_i),
		.ld_stb_i(ld_stb), .ld_req_i(ld_req),
		.mem_stb_o(mem_stb), .mem_req_o(mem_req), .mem_rdata_i(mem_rdata),
		.reg_stb_o(reg_stb), .reg_req_o(reg_req), .reg_rdata_i(reg_rdata),
		.rsp_stb_o(rsp_stb_o), .rsp_o(rsp_o)
	);

	word_ram word_ram_i (
		.clk_i(clk_i), .mem_stb_i(mem_stb), .mem_req_i(mem_req), .rdata_o(mem_rdata)
	);

	// Output side
	periph_regs periph_regs_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .reprog_i(reprog_i),
		.reg_stb_i(reg_stb), .reg_req_i(reg_req), .rdata_o(reg_rdata),
		.sw_i(sw_i), .led_o(led_o),
		.tx_busy_i(tx_busy), .tx_stb_o(tx_stb), .tx_byte_o(tx_byte)
	);

	uart_tx uart_tx_i0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .tx_stb_i(tx_stb), .tx_byte_i(tx_byte),
		.busy_o(tx_busy), .tx_o(uart_tx_o)
	);

endmodule

// File: verif/tb_soc.sv
`timescale 1ns/10ps

module tb_soc;
	import soc_pkg::*;

	localparam int MAX_CMDS = 64;
	localparam int RSP_TIMEOUT = 8;
	localparam int SERIAL_TIMEOUT = 20 * CLKS_PER_BIT;

	logic clk_i;
	logic rst_n_i;
	logic req_stb_i;
	bus_req_t req_i;
	logic rsp_stb_o;
	bus_rsp_t rsp_o;
	logic reprog_i;
	logic [SW_W-1:0] sw_i;
	logic [LED_W-1:0] led_o;
	logic uart_rx_i;
	logic uart_tx_o;

	// Five words per command: cmd a b c d
	logic [31:0] stim [5*MAX_CMDS];
	logic [7:0] serial_q [$];
	integer seed;
	int checks;
	int errors;
	int timeouts;

	soc_top soc_top_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .req_stb_i(req_stb_i), .req_i(req_i),
		.rsp_stb_o(rsp_stb_o), .rsp_o(rsp_o), .reprog_i(reprog_i), .sw_i(sw_i),
		.led_o(led_o), .uart_rx_i(uart_rx_i), .uart_tx_o(uart_tx_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	task automatic drive_req(input logic wr, input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		req_i.write = wr;
		req_i.addr  = addr;
		req_i.wdata = data;
		req_i.strb  = strb;
		req_stb_i   = 1'b1;
	endtask

	// Request at this falling edge, response expected at the next one
	task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output bus_rsp_t rsp);
		int cycles;
		drive_req(wr, addr, data, strb);
		@(negedge clk_i);
		req_stb_i = 1'b0;
		cycles = 1;
		while (rsp_stb_o !== 1'b1 && cycles < RSP_TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		rsp = rsp_o;
		checks++;
		if (rsp_stb_o !== 1'b1) begin
			$display("Timeout at %0t: no bus response for address %h", $time, addr);
			timeouts++;
		end else if (cycles != 1) begin
			$display("ERROR %0t: response to %h came after %0d cycles", $time, addr, cycles);
			errors++;
		end
	endtask

	task automatic check_slot(input logic [31:0] addr, input logic [31:0] exp_data);
		checks++;
		if (rsp_stb_o !== 1'b1 || rsp_o.rdata !== exp_data || rsp_o.err !== 1'b0) begin
			$display("ERROR %0t: back-to-back read %h gave stb %b data %h, expected %h",
				$time, addr, rsp_stb_o, rsp_o.rdata, exp_data);
			errors++;
		end
	endtask

	task automatic send_uart_byte(input logic [7:0] value);
		uart_rx_i = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk_i);
		for (int i = 0; i < 8; i++) begin
			uart_rx_i = value[i];
			repeat (CLKS_PER_BIT) @(negedge clk_i);
		end
		uart_rx_i = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk_i);
	endtask

	// Decodes every frame on the transmit line into serial_q
	initial begin : serial_monitor
		logic [7:0] value;
		@(posedge rst_n_i);
		forever begin
			@(negedge clk_i);
			if (uart_tx_o === 1'b0) begin
				repeat (CLKS_PER_BIT/2) @(negedge clk_i);
				if (uart_tx_o !== 1'b0) begin
					$display("ERROR %0t: start bit not held to mid-bit", $time);
					errors++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk_i);
					value[i] = uart_tx_o;
				end
				repeat (CLKS_PER_BIT) @(negedge clk_i);
				if (uart_tx_o !== 1'b1) begin
					$display("ERROR %0t: stop bit missing on transmit line", $time);
					errors++;
				end
				serial_q.push_back(value);
			end
		end
	end

	initial begin : run
		int unsigned gap;
		int pc;
		int cycles;
		bit done;
		logic [31:0] cmd, a, b, c, d;
		bus_rsp_t rsp;
		req_stb_i = 1'b0;
		req_i     = '0;
		reprog_i  = 1'b0;
		sw_i      = '0;
		uart_rx_i = 1'b1;
		rst_n_i   = 1'b0;
		seed      = 32'ha5b1;
		checks    = 0;
		errors    = 0;
		timeouts  = 0;
		$readmemh("verif/soc_stim.txt", stim);
		repeat (10) @(negedge clk_i);
		rst_n_i = 1'b1;
		pc = 0;
		done = 1'b0;
		while (!done && pc < MAX_CMDS) begin
			cmd = stim[5*pc];
			a = stim[5*pc+1];
			b = stim[5*pc+2];
			c = stim[5*pc+3];
			d = stim[5*pc+4];
			pc++;
			gap = 1 + ($random(seed) & 32'h3);
			repeat (gap) @(negedge clk_i);
			case (cmd)
				0: done = 1'b1;
				1: sw_i = a[SW_W-1:0];
				2: reprog_i = a[0];
				3: send_uart_byte(a[7:0]);
				4: bus_access(1'b1, a, b, c[3:0], rsp);
				5: begin
					bus_access(1'b0, a, '0, '0, rsp);
					checks++;
					if (rsp.rdata !== b || rsp.err !== c[0]) begin
						$display("ERROR %0t: read %h gave %h err %b, expected %h err %b",
							$time, a, rsp.rdata, rsp.err, b, c[0]);
						errors++;
					end
				end
				6: begin
					checks++;
					if (led_o !== a[LED_W-1:0]) begin
						$display("ERROR %0t: led_o is %h, expected %h", $time, led_o, a[LED_W-1:0]);
						errors++;
					end
				end
				7: begin
					cycles = 0;
					while (serial_q.size() == 0 && cycles < SERIAL_TIMEOUT) begin
						@(negedge clk_i);
						cycles++;
					end
					checks++;
					if (serial_q.size() == 0) begin
						$display("Timeout at %0t: no serial byte came out of the UART", $time);
						timeouts++;
					end else if (serial_q[0] !== a[7:0]) begin
						$display("ERROR %0t: serial byte %h, expected %h", $time, serial_q[0], a[7:0]);
						errors++;
						void'(serial_q.pop_front());
					end else begin
						void'(serial_q.pop_front());
					end
				end
				8: begin
					drive_req(1'b0, a, '0, '0);
					@(negedge clk_i);
					drive_req(1'b0, c, '0, '0);
					check_slot(a, b);
					@(negedge clk_i);
					req_stb_i = 1'b0;
					check_slot(c, d);
					@(negedge clk_i);
					checks++;
					if (rsp_stb_o !== 1'b0) begin
						$display("ERROR %0t: extra response after back-to-back reads", $time);
						errors++;
					end
				end
				9: begin
					drive_req(1'b0, a, '0, '0);
					@(negedge clk_i);
					req_stb_i = 1'b0;
					for (int i = 0; i < 4; i++) begin
						checks++;
						if (rsp_stb_o !== 1'b0) begin
							$display("ERROR %0t: response to %h during reprogramming", $time, a);
							errors++;
						end
						@(negedge clk_i);
					end
				end
				default: begin
					$display("Stimulus file is missing, or command %0d is not valid: %h", pc, cmd);
					errors++;
					done = 1'b1;
				end
			endcase
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verif/soc_stim.txt
// cmd a b c d: 1 switches, 2 reprogram, 3 UART byte, 4 write addr data strb, 5 read addr data err
// 6 LED value, 7 serial byte, 8 read pair addr0 data0 addr1 data1, 9 read ignored, 0 end
1 00000009 00000000 0 0
2 00000001 00000000 0 0
3 00000011 00000000 0 0
3 00000022 00000000 0 0
3 00000033 00000000 0 0
3 00000044 00000000 0 0
3 00000055 00000000 0 0
3 00000066 00000000 0 0
3 00000077 00000000 0 0
3 00000088 00000000 0 0
9 00000000 00000000 0 0
2 00000000 00000000 0 0
5 00000000 44332211 0 0
5 00000004 88776655 0 0
4 00000010 AABBCCDD F 0
4 00000010 00110000 4 0
4 00000010 0000EE00 2 0
5 00000010 AA11EEDD 0 0
4 00001000 123456A5 1 0
6 000000A5 00000000 0 0
5 00001000 00000009 0 0
2 00000001 00000000 0 0
6 00000000 00000000 0 0
2 00000000 00000000 0 0
4 00002000 0000005A 1 0
5 00002004 00000001 0 0
7 0000005A 00000000 0 0
5 00003000 00000000 1 0
4 00000400 DEADBEEF F 0
5 00000000 44332211 0 0
8 00000000 44332211 00000004 88776655
0 00000000 00000000 0 0

// File: vlog.f
source/soc_pkg.sv
source/uart_rx.sv
source/prog_loader.sv
source/bus_fabric.sv
source/word_ram.sv
source/periph_regs.sv
source/uart_tx.sv
source/soc_top.sv
verif/tb_soc.sv

// File: Bender.yml
package:
  name: soc

sources:
  - source/soc_pkg.sv
  - source/uart_rx.sv
  - source/prog_loader.sv
  - source/bus_fabric.sv
  - source/word_ram.sv
  - source/periph_regs.sv
  - source/uart_tx.sv
  - source/soc_top.sv
  - target: test
    files:
      - verif/tb_soc.sv
